/* src/div_pkg.sv */
`default_nettype none

package div_pkg;

    localparam int xlen       = 32;
    localparam int pos_w      = 6;  // Holds 0..32, so a full-width magnitude has a position
    localparam int reg_addr_w = 5;

    // Request from the execute stage, one per divide
    typedef struct packed {
        logic                  en;
        logic                  rem_op;     // 1 returns the remainder
        logic                  signed_op;
        logic [xlen-1:0]       sr0;        // Dividend
        logic [xlen-1:0]       sr1;        // Divisor
        logic [reg_addr_w-1:0] addr;
    } div_req_t;

    // Shared by the iterative and the early-out result ports
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       result;
        logic [reg_addr_w-1:0] addr;
    } div_resp_t;

    typedef enum logic [1:0] {
        state_idle    = 2'd0,
        state_iterate = 2'd1,
        state_finish  = 2'd2
    } div_state_t;

endpackage

`default_nettype wire

/* src/lead_one_pos.sv */
`timescale 1ns/1ps
`default_nettype none

module lead_one_pos
    import div_pkg::*;
(
    input  logic [xlen-1:0]  value,
    output logic [pos_w-1:0] pos
);

    // Later iterations overwrite earlier ones, so the highest set bit wins
    always_comb begin
        pos = '0;
        for (int i = 0; i < xlen; i++) begin
            if (value[i]) begin
                pos = pos_w'(i + 1);
            end
        end
    end

endmodule

`default_nettype wire

/* src/div_operand_prep.sv */
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep
    import div_pkg::*;
(
    input  div_req_t           req,
    output logic [xlen-1:0]    dividend_mag,
    output logic [2*xlen-1:0]  divisor_aligned,
    output logic [pos_w-1:0]   step_count,
    output logic               dividend_neg,
    output logic               divisor_neg,
    output logic               early_out
);

    logic [xlen-1:0]  divisor_mag;
    logic [pos_w-1:0] dividend_pos;
    logic [pos_w-1:0] divisor_pos;
    logic [pos_w-1:0] shift;

    assign dividend_neg = req.signed_op & req.sr0[xlen-1];
    assign divisor_neg  = req.signed_op & req.sr1[xlen-1];

    // The signed minimum stays 0x80000000 here, which reads correctly as unsigned
    assign dividend_mag = dividend_neg ? -req.sr0 : req.sr0;
    assign divisor_mag  = divisor_neg ? -req.sr1 : req.sr1;

    lead_one_pos u_dividend_pos (
        .value (dividend_mag),
        .pos   (dividend_pos)
    );

    lead_one_pos u_divisor_pos (
        .value (divisor_mag),
        .pos   (divisor_pos)
    );

    // Quotient is zero, or the divisor is zero, so no iteration is needed
    assign early_out = (divisor_pos == '0) || (dividend_pos < divisor_pos);

    assign shift           = dividend_pos - divisor_pos;
    assign divisor_aligned = (2*xlen)'(divisor_mag) << shift;
    assign step_count      = shift + pos_w'(1);  // One step per quotient bit

    always_comb begin
        step_bound: assert #0 (!(req.en && !early_out) || step_count <= pos_w'(xlen))
            else $error("Divide step count %0d exceeds operand width", step_count);
    end

endmodule

`default_nettype wire

/* src/div_step_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module div_step_counter
    import div_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic [pos_w-1:0] load_value,
    input  logic             step,
    output logic             last_step
);

    logic [pos_w-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (step) begin
            count <= count - pos_w'(1);
        end
    end

    assign last_step = (count == pos_w'(1));

    // The controller must stop stepping once the loaded count has run out
    step_needs_count: assert property (@(posedge clk) disable iff (rst)
        step |-> count != '0)
        else $error("Divide step issued with an empty step counter");

endmodule

`default_nettype wire

/* src/div_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module div_ctrl
    import div_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic req_en,
    input  logic early_out,
    input  logic last_step,
    output logic load,
    output logic quick,
    output logic step,
    output logic finish,
    output logic busy
);

    div_state_t state;
    div_state_t state_next;
    logic       accept;

    assign accept = (state == state_idle) && req_en;  // Requests outside idle are dropped
    assign quick  = accept && early_out;
    assign load   = accept && !early_out;
    assign step   = (state == state_iterate);
    assign finish = (state == state_finish);

    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (load) begin
                    state_next = state_iterate;
                end
            end
            state_iterate: begin
                if (last_step) begin
                    state_next = state_finish;
                end
            end
            state_finish: state_next = state_idle;
            default:      state_next = state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= state_idle;
            busy  <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                busy <= 1'b1;
            end else if (finish) begin
                busy <= 1'b0;  // Drops as the result leaves div_result_fix
            end
        end
    end

    one_path: assert property (@(posedge clk) disable iff (rst)
        !(load && quick))
        else $error("Divide request sent down both paths, state %s", state.name());

endmodule

`default_nettype wire

/* src/div_shift_sub.sv */
`timescale 1ns/1ps
`default_nettype none

module div_shift_sub
    import div_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  logic              step,
    input  logic [xlen-1:0]   dividend_mag,
    input  logic [2*xlen-1:0] divisor_aligned,
    output logic [xlen-1:0]   remainder,
    output logic [xlen-1:0]   quotient
);

    logic [xlen-1:0]   rem_q;
    logic [2*xlen-1:0] divisor_q;
    logic [xlen-1:0]   quo_q;
    logic              fits;

    // Restoring step: subtract only when the shifted divisor fits
    assign fits = (2*xlen)'(rem_q) >= divisor_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_q     <= '0;
            divisor_q <= '0;
            quo_q     <= '0;
        end else if (load) begin
            rem_q     <= dividend_mag;
            divisor_q <= divisor_aligned;
            quo_q     <= '0;
        end else if (step) begin
            if (fits) begin
                rem_q <= rem_q - divisor_q[xlen-1:0];  // Divisor fits in xlen whenever it fits
            end
            quo_q     <= {quo_q[xlen-2:0], fits};
            divisor_q <= divisor_q >> 1;
        end
    end

    assign remainder = rem_q;
    assign quotient  = quo_q;

endmodule

`default_nettype wire

/* src/div_result_fix.sv */
`timescale 1ns/1ps
`default_nettype none

module div_result_fix
    import div_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            load,
    input  logic            quick,
    input  logic            finish,
    input  div_req_t        req,
    input  logic            dividend_neg,
    input  logic            divisor_neg,
    input  logic [xlen-1:0] remainder,
    input  logic [xlen-1:0] quotient,
    output div_resp_t       resp,
    output div_resp_t       quick_resp
);

    logic                  rem_op_q;
    logic                  dividend_neg_q;
    logic                  divisor_neg_q;
    logic [reg_addr_w-1:0] addr_q;
    logic [xlen-1:0]       quo_fixed;
    logic [xlen-1:0]       rem_fixed;

    always_ff @(posedge clk) begin
        if (load) begin
            rem_op_q       <= req.rem_op;
            dividend_neg_q <= dividend_neg;
            divisor_neg_q  <= divisor_neg;
            addr_q         <= req.addr;
        end
    end

    // Quotient truncates toward zero, remainder follows the dividend sign
    assign quo_fixed = (dividend_neg_q ^ divisor_neg_q) ? -quotient : quotient;
    assign rem_fixed = dividend_neg_q ? -remainder : remainder;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp       <= '0;
            quick_resp <= '0;
        end else begin
            resp       <= '0;  // Fields read zero outside the valid pulse
            quick_resp <= '0;
            if (finish) begin
                resp.valid  <= 1'b1;
                resp.result <= rem_op_q ? rem_fixed : quo_fixed;
                resp.addr   <= addr_q;
            end
            if (quick) begin
                quick_resp.valid  <= 1'b1;
                quick_resp.result <= req.rem_op ? req.sr0 : '0;
                quick_resp.addr   <= req.addr;
            end
        end
    end

endmodule

`default_nettype wire

/* src/iter_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module iter_divider
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  div_req_t  req,
    output div_resp_t resp,
    output div_resp_t quick_resp,
    output logic      busy
);

    logic [xlen-1:0]   dividend_mag;
    logic [2*xlen-1:0] divisor_aligned;
    logic [pos_w-1:0]  step_count;
    logic              dividend_neg;
    logic              divisor_neg;
    logic              early_out;
    logic              load;
    logic              quick;
    logic              step;
    logic              finish;
    logic              last_step;
    logic [xlen-1:0]   remainder;
    logic [xlen-1:0]   quotient;

    div_operand_prep u_prep (
        .req             (req),
        .dividend_mag    (dividend_mag),
        .divisor_aligned (divisor_aligned),
        .step_count      (step_count),
        .dividend_neg    (dividend_neg),
        .divisor_neg     (divisor_neg),
        .early_out       (early_out)
    );

    div_step_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .load_value (step_count),
        .step       (step),
        .last_step  (last_step)
    );

    div_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_en    (req.en),
        .early_out (early_out),
        .last_step (last_step),
        .load      (load),
        .quick     (quick),
        .step      (step),
        .finish    (finish),
        .busy      (busy)
    );

    div_shift_sub u_shift_sub (
        .clk             (clk),
        .rst             (rst),
        .load            (load),
        .step            (step),
        .dividend_mag    (dividend_mag),
        .divisor_aligned (divisor_aligned),
        .remainder       (remainder),
        .quotient        (quotient)
    );

    div_result_fix u_result_fix (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .quick        (quick),
        .finish       (finish),
        .req          (req),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .remainder    (remainder),
        .quotient     (quotient),
        .resp         (resp),
        .quick_resp   (quick_resp)
    );

endmodule

`default_nettype wire

/* test/tb_iter_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_iter_divider
    import div_pkg::*;
();

    logic      clk;
    logic      rst;
    div_req_t  req;
    div_resp_t resp;
    div_resp_t quick_resp;
    logic      busy;

    // Expected record for the one divide in flight
    logic        acc;
    logic        early_now;
    logic [31:0] result_now;
    int          latency_now;
    logic [31:0] exp_result;
    logic [4:0]  exp_addr;
    logic        iter_pending;
    int          due_cycle;
    int          cycle;

    iter_divider DUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .resp       (resp),
        .quick_resp (quick_resp),
        .busy       (busy)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] magnitude(logic is_signed, logic [31:0] v);
        return (is_signed && v[31]) ? (32'd0 - v) : v;
    endfunction

    // Number of bits up to and including the leading one
    function automatic int bit_length(logic [31:0] v);
        int n;
        n = 0;
        while (v != 32'd0) begin
            v = v >> 1;
            n++;
        end
        return n;
    endfunction

    function automatic logic takes_early_out(div_req_t r);
        int len_a;
        int len_b;
        len_a = bit_length(magnitude(r.signed_op, r.sr0));
        len_b = bit_length(magnitude(r.signed_op, r.sr1));
        return (r.sr1 == 32'd0) || (len_a < len_b);
    endfunction

    function automatic int iter_latency(div_req_t r);
        return bit_length(magnitude(r.signed_op, r.sr0))
            - bit_length(magnitude(r.signed_op, r.sr1)) + 3;
    endfunction

    function automatic logic [31:0] expected_result(div_req_t r);
        logic [31:0] q;
        logic [31:0] rm;
        if (r.sr1 == 32'd0) begin
            q  = 32'd0;
            rm = r.sr0;
        end else if (r.signed_op && r.sr0 == 32'h8000_0000 && r.sr1 == 32'hffff_ffff) begin
            q  = 32'h8000_0000;
            rm = 32'd0;
        end else if (r.signed_op) begin
            q  = $signed(r.sr0) / $signed(r.sr1);  // Truncates toward zero
            rm = $signed(r.sr0) % $signed(r.sr1);
        end else begin
            q  = r.sr0 / r.sr1;
            rm = r.sr0 % r.sr1;
        end
        return r.rem_op ? rm : q;
    endfunction

    task automatic stop_with_error(string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_check(string msg);
        stop_with_error($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    // Busy low means the controller sits in idle
    always_comb begin
        acc         = req.en && !busy;
        early_now   = takes_early_out(req);
        result_now  = expected_result(req);
        latency_now = iter_latency(req);
    end

    always @(posedge clk) begin
        if (rst) begin
            cycle        <= 0;
            iter_pending <= 1'b0;
            due_cycle    <= 0;
            exp_result   <= 32'd0;
            exp_addr     <= 5'd0;
        end else begin
            cycle <= cycle + 1;
            if (iter_pending && cycle == due_cycle) begin
                iter_pending <= 1'b0;
            end
            if (acc) begin
                exp_result <= result_now;
                exp_addr   <= req.addr;
                if (!early_now) begin
                    iter_pending <= 1'b1;
                    due_cycle    <= cycle + latency_now;
                end
            end
        end
    end

    reset_clear: assert property (@(posedge clk)
        rst |=> resp == '0 && quick_resp == '0 && !busy)
        else report_check("outputs not cleared by reset");

    quick_path: assert property (@(posedge clk) disable iff (rst)
        acc && early_now |=> quick_resp.valid && quick_resp.result == exp_result
            && quick_resp.addr == exp_addr)
        else report_check("early-out result or addr wrong");

    no_stray_quick: assert property (@(posedge clk) disable iff (rst)
        !(acc && early_now) |=> !quick_resp.valid)
        else report_check("quick_resp.valid without an accepted early-out request");

    iter_result: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> iter_pending && cycle == due_cycle
            && resp.result == exp_result && resp.addr == exp_addr)
        else report_check("iterative result, addr or latency wrong");

    iter_due: assert property (@(posedge clk) disable iff (rst)
        iter_pending && cycle == due_cycle |-> resp.valid)
        else report_check("resp.valid missing at the expected cycle");

    busy_track: assert property (@(posedge clk) disable iff (rst)
        iter_pending |-> busy == (cycle != due_cycle))
        else report_check("busy wrong while an iterative divide runs");

    idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        !iter_pending |-> !busy)
        else report_check("busy high with no iterative divide");

    fields_zero: assert property (@(posedge clk) disable iff (rst)
        (!resp.valid |-> resp == '0) and (!quick_resp.valid |-> quick_resp == '0))
        else report_check("result fields not zero outside the valid pulse");

    task automatic drive_request(logic rem_op, logic signed_op, logic [31:0] a,
                                 logic [31:0] b, logic [4:0] addr);
        req.en        = 1'b1;
        req.rem_op    = rem_op;
        req.signed_op = signed_op;
        req.sr0       = a;
        req.sr1       = b;
        req.addr      = addr;
    endtask

    task automatic wait_until_idle();
        int n;
        n = 0;
        while (busy && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            stop_with_error("Timeout: busy did not fall within 40 cycles");
        end
    endtask

    // Called one falling edge after acceptance
    task automatic wait_for_result(logic [4:0] addr);
        int  n;
        logic got;
        got = quick_resp.valid;
        for (n = 0; n < 40 && !got; n++) begin
            @(negedge clk);
            got = resp.valid;
        end
        if (!got) begin
            stop_with_error($sformatf("Timeout: no result arrived for addr %0d", addr));
        end
    endtask

    task automatic run_request(logic rem_op, logic signed_op, logic [31:0] a,
                               logic [31:0] b, logic [4:0] addr);
        wait_until_idle();
        drive_request(rem_op, signed_op, a, b, addr);
        @(negedge clk);
        req.en = 1'b0;
        wait_for_result(addr);
    endtask

    // Longest divide, with requests held on req while busy is high
    task automatic issue_during_busy(logic [4:0] addr);
        int i;
        wait_until_idle();
        drive_request(1'b0, 1'b0, 32'hffff_ffff, 32'h1, addr);
        @(negedge clk);
        for (i = 0; i < 6; i++) begin
            drive_request(1'(i), 1'b0, 32'h1234_5678, (i % 2 == 0) ? 32'd0 : 32'd3, ~addr);
            @(negedge clk);
        end
        req.en = 1'b0;
        wait_for_result(addr);
    endtask

    initial begin
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        void'($urandom(32'h9444_b1ea));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        run_request(1'b0, 1'b0, 32'd5, 32'd100, 5'd1);       // Short dividend
        run_request(1'b1, 1'b1, -32'sd5, 32'd100, 5'd2);
        run_request(1'b0, 1'b0, 32'd77, 32'd0, 5'd3);        // Divide by zero
        run_request(1'b1, 1'b1, -32'sd77, 32'd0, 5'd4);
        run_request(1'b0, 1'b1, 32'd100, 32'd7, 5'd5);
        run_request(1'b1, 1'b1, 32'd100, 32'd7, 5'd6);
        run_request(1'b0, 1'b1, -32'sd100, 32'd7, 5'd7);
        run_request(1'b1, 1'b1, -32'sd100, 32'd7, 5'd8);
        run_request(1'b0, 1'b1, 32'd100, -32'sd7, 5'd9);
        run_request(1'b1, 1'b1, 32'd100, -32'sd7, 5'd10);
        run_request(1'b0, 1'b1, -32'sd100, -32'sd7, 5'd11);
        run_request(1'b1, 1'b1, -32'sd100, -32'sd7, 5'd12);
        run_request(1'b0, 1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd13);
        run_request(1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd14);
        run_request(1'b0, 1'b0, 32'h8000_0000, 32'd1, 5'd15);
        run_request(1'b1, 1'b0, 32'hffff_ffff, 32'd10, 5'd16);
        issue_during_busy(5'd17);

        for (i = 0; i < 200; i++) begin
            a = $urandom >> ($urandom % 32);
            b = ($urandom % 16 == 0) ? 32'd0 : ($urandom >> ($urandom % 32));
            run_request(1'($urandom), 1'($urandom), a, b, 5'($urandom));
        end

        repeat (3) @(negedge clk);  // Let the last response reach its checks
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* iter_divider.f */
src/div_pkg.sv
src/lead_one_pos.sv
src/div_operand_prep.sv
src/div_step_counter.sv
src/div_ctrl.sv
src/div_shift_sub.sv
src/div_result_fix.sv
src/iter_divider.sv
test/tb_iter_divider.sv
